//--- src.f
mario_pkg.sv
mario_collision.sv
mario_motion.sv
mario_fsm.sv
mario_sprite.sv
mario.sv
mario_checker.sv
tb_mario.sv

//--- tb_mario.sv
`default_nettype none

module tb_mario;

    localparam int STIM_CYCLES = 1500;
    // a segment can run up to about 220 cycles past the stimulus budget
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 500;
    // column centres of the five ladders
    localparam int LADDER_X [5] = '{346, 548, 55, 553, 60};

    logic              clk;
    logic              rst;
    logic              start;
    logic              over;
    mario_pkg::keys_t  keys;
    mario_pkg::x_t     x;
    mario_pkg::y_t     y;
    mario_pkg::state_t state;
    mario_pkg::frame_t frame;
    int                x_errors;
    int                y_errors;
    int                state_errors;
    int                frame_errors;
    int                seed;
    int                stim_count;
    int                cycle_count = 0;
    int                kind;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    mario i_mario (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .over  (over),
        .keys  (keys),
        .x     (x),
        .y     (y),
        .state (state),
        .frame (frame)
    );

    mario_checker i_checker (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .over         (over),
        .keys         (keys),
        .x            (x),
        .y            (y),
        .state        (state),
        .frame        (frame),
        .x_errors     (x_errors),
        .y_errors     (y_errors),
        .state_errors (state_errors),
        .frame_errors (frame_errors)
    );

    function automatic int pick(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return lo + r % (hi - lo + 1);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        stim_count++;
    endtask

    // walk toward a column, keys released while airborne
    task automatic steer_to(input int target, input int max_cycles);
        for (int i = 0; i < max_cycles; i++) begin
            keys = '0;
            if (state == mario_pkg::STANDING || state == mario_pkg::WALKING) begin
                if (x > target + 2) begin
                    keys.left = 1'b1;
                end else if (x < target - 2) begin
                    keys.right = 1'b1;
                end
            end
            next_cycle();
        end
    endtask

    task automatic die_and_restart();
        over = 1'b1;
        next_cycle();
        over = 1'b0;
        keys = 5'(pick(0, 31));
        repeat (pick(36, 48)) next_cycle();
        rst = 1'b1;
        next_cycle();
        next_cycle();
        rst   = 1'b0;
        start = 1'b0;
        next_cycle();
        start = 1'b1;
    endtask

    task automatic print_counts();
        $display("errors: x %0d, y %0d, state %0d, frame %0d",
                 x_errors, y_errors, state_errors, frame_errors);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        seed       = 32'h9a87;
        stim_count = 0;
        rst        = 1'b1;
        start      = 1'b0;
        over       = 1'b0;
        keys       = '0;
        next_cycle();
        next_cycle();
        rst = 1'b0;
        next_cycle();
        next_cycle();
        start = 1'b1;
        while (stim_count < STIM_CYCLES) begin
            kind = pick(0, 9);
            if (kind <= 4) begin
                keys = 5'(pick(0, 31));
                repeat (pick(4, 40)) next_cycle();
            end else if (kind <= 7) begin
                steer_to(LADDER_X[pick(0, 4)], 160);
                keys = '0;
                if (pick(0, 1) == 1) begin
                    keys.up = 1'b1;
                end else begin
                    keys.down = 1'b1;
                end
                repeat (pick(10, 60)) next_cycle();
            end else if (kind == 8) begin
                steer_to(pick(10, 620), 160);
                keys       = '0;
                keys.jump  = 1'b1;
                keys.left  = 1'(pick(0, 1));
                keys.right = 1'(pick(0, 1));
                repeat (pick(4, 40)) next_cycle();
            end else begin
                die_and_restart();
            end
        end
        keys = '0;
        repeat (4) next_cycle();
        print_counts();
        if (x_errors + y_errors + state_errors + frame_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mario_checker.sv
`default_nettype none

module mario_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              over,
    input  mario_pkg::keys_t  keys,
    input  mario_pkg::x_t     x,
    input  mario_pkg::y_t     y,
    input  mario_pkg::state_t state,
    input  mario_pkg::frame_t frame,
    output int                x_errors,
    output int                y_errors,
    output int                state_errors,
    output int                frame_errors
);

    mario_pkg::state_t m_state;
    int                m_x;
    int                m_y;
    int                m_vx;
    int                m_vy;
    int                m_cnt;
    bit                m_face;
    bit                armed;

    initial begin
        x_errors     = 0;
        y_errors     = 0;
        state_errors = 0;
        frame_errors = 0;
        armed        = 1'b0;
    end

    function automatic bit over_plat(input int px, input int i);
        return px < int'(mario_pkg::PLATFORMS[i].rx) &&
               px + int'(mario_pkg::WIDTH) > int'(mario_pkg::PLATFORMS[i].lx);
    endfunction

    function automatic bit grounded(input int px, input int py);
        int feet;
        feet = py + int'(mario_pkg::HEIGHT);
        if (feet >= int'(mario_pkg::BOTTOM_EDGE)) begin
            return 1'b1;
        end
        for (int i = 0; i < mario_pkg::NUM_PLATFORMS; i++) begin
            if (over_plat(px, i) && feet >= int'(mario_pkg::PLATFORMS[i].ly) &&
                    feet <= int'(mario_pkg::PLATFORMS[i].ry)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic bit at_ladder(input int px, input int py);
        for (int i = 0; i < mario_pkg::NUM_LADDERS; i++) begin
            if (px >= int'(mario_pkg::LADDERS[i].lx) && px <= int'(mario_pkg::LADDERS[i].rx) &&
                    py > int'(mario_pkg::LADDERS[i].ly) && py < int'(mario_pkg::LADDERS[i].ry)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // row to land on after the step, or -1 while still in the air
    function automatic int landing_row(input int px, input int feet_next);
        if (feet_next > int'(mario_pkg::BOTTOM_EDGE)) begin
            return int'(mario_pkg::BOTTOM_EDGE) - int'(mario_pkg::HEIGHT);
        end
        for (int i = 0; i < mario_pkg::NUM_PLATFORMS; i++) begin
            if (over_plat(px, i) && feet_next > int'(mario_pkg::PLATFORMS[i].ly) &&
                    feet_next < int'(mario_pkg::PLATFORMS[i].ry)) begin
                return int'(mario_pkg::PLATFORMS[i].ly) - int'(mario_pkg::HEIGHT);
            end
        end
        return -1;
    endfunction

    function automatic int clamp_x(input int xs);
        if (xs < int'(mario_pkg::LEFT_EDGE)) begin
            return int'(mario_pkg::LEFT_EDGE);
        end
        if (xs + int'(mario_pkg::WIDTH) > int'(mario_pkg::RIGHT_EDGE)) begin
            return int'(mario_pkg::RIGHT_EDGE) - int'(mario_pkg::WIDTH);
        end
        return xs;
    endfunction

    function automatic mario_pkg::state_t next_state(input bit gnd, input bit lad);
        bit side_free;
        side_free = (keys.left && m_x > int'(mario_pkg::LEFT_EDGE)) ||
                    (keys.right && m_x + int'(mario_pkg::WIDTH) < int'(mario_pkg::RIGHT_EDGE));
        if (m_state == mario_pkg::INITIAL) begin
            return start ? mario_pkg::STANDING : mario_pkg::INITIAL;
        end
        if (m_state == mario_pkg::DYING || over) begin
            return mario_pkg::DYING;
        end
        case (m_state)
            mario_pkg::STANDING, mario_pkg::WALKING: begin
                if (!gnd) return mario_pkg::FLYING;
                if (keys.jump) return mario_pkg::JUMPING;
                if ((keys.up || keys.down) && lad) return mario_pkg::CLIMBING;
                return (keys.left || keys.right) ? mario_pkg::WALKING : mario_pkg::STANDING;
            end
            mario_pkg::JUMPING: return mario_pkg::FLYING;
            mario_pkg::FLYING: begin
                return (gnd && m_vy >= 0) ? mario_pkg::STANDING : mario_pkg::FLYING;
            end
            mario_pkg::CLIMBING: begin
                if (gnd && keys.jump) return mario_pkg::JUMPING;
                if (side_free) return mario_pkg::WALKING;
                return lad ? mario_pkg::CLIMBING : mario_pkg::STANDING;
            end
            default: return mario_pkg::INITIAL;
        endcase
    endfunction

    task automatic move_body();
        int xs;
        int dy;
        int row;
        xs = m_x + m_vx;
        case (m_state)
            mario_pkg::INITIAL: begin
                m_x = int'(mario_pkg::START_X);
                m_y = int'(mario_pkg::START_Y);
            end
            mario_pkg::JUMPING: m_vy = -int'(mario_pkg::JUMP_VEL);
            mario_pkg::FLYING: begin
                m_cnt = (m_cnt + 1) & 31;
                // tenths to whole pixels, toward zero
                dy  = m_vy / 10;
                row = landing_row(m_x, m_y + dy + int'(mario_pkg::HEIGHT));
                if (m_y + dy < int'(mario_pkg::TOP_EDGE)) begin
                    m_y  = int'(mario_pkg::TOP_EDGE);
                    m_vy = 0;
                end else if (row >= 0) begin
                    m_y  = row;
                    m_vy = 0;
                end else begin
                    m_y  = m_y + dy;
                    m_vy = m_vy + int'(mario_pkg::GRAVITY);
                end
                if (clamp_x(xs) != xs) begin
                    m_vx = 0;
                end
                m_x = clamp_x(xs);
            end
            mario_pkg::WALKING: begin
                m_cnt = (m_cnt + 1) & 31;
                if (keys.left) begin
                    m_vx   = -int'(mario_pkg::WALK_SPEED);
                    m_face = 1'b1;
                end else if (keys.right) begin
                    m_vx   = int'(mario_pkg::WALK_SPEED);
                    m_face = 1'b0;
                end
                m_x = clamp_x(xs);
            end
            mario_pkg::CLIMBING: begin
                m_vx = 0;
                m_vy = 0;
                if (keys.up || keys.down) begin
                    m_cnt = (m_cnt + 1) & 31;
                end
                if (keys.up) begin
                    m_y = m_y - 3 < int'(mario_pkg::TOP_EDGE) ? int'(mario_pkg::TOP_EDGE) : m_y - 3;
                end else if (keys.down) begin
                    m_y = (m_y + 39 > int'(mario_pkg::BOTTOM_EDGE)) ?
                          int'(mario_pkg::BOTTOM_EDGE) - int'(mario_pkg::HEIGHT) : m_y + 3;
                end
            end
            default: begin
                m_vx = 0;
                m_vy = 0;
                if (m_state == mario_pkg::DYING) begin
                    m_cnt = (m_cnt + 1) & 31;
                end
            end
        endcase
    endtask

    function automatic mario_pkg::frame_t expected_frame();
        bit right;
        right = m_vx > 0;
        case (m_state)
            mario_pkg::FLYING: return m_face ? mario_pkg::FLY_LEFT : mario_pkg::FLY_RIGHT;
            mario_pkg::WALKING: begin
                if (m_cnt[3:2] == 2'd0) return right ? mario_pkg::WALK_RIGHT1 : mario_pkg::WALK_LEFT1;
                if (m_cnt[3:2] == 2'd2) return right ? mario_pkg::WALK_RIGHT2 : mario_pkg::WALK_LEFT2;
                return right ? mario_pkg::WALK_RIGHT3 : mario_pkg::WALK_LEFT3;
            end
            mario_pkg::DYING: begin
                if (m_cnt[4:3] == 2'd0) return mario_pkg::DIE1;
                if (m_cnt[4:3] == 2'd1) return mario_pkg::DIE2;
                if (m_cnt[4:3] == 2'd2) return mario_pkg::DIE3;
                return mario_pkg::DIE4;
            end
            mario_pkg::CLIMBING: begin
                return ((keys.up || keys.down) && m_cnt[2]) ? mario_pkg::CLIMB2 : mario_pkg::CLIMB1;
            end
            default: return m_face ? mario_pkg::WALK_LEFT3 : mario_pkg::WALK_RIGHT3;
        endcase
    endfunction

    task automatic show_mismatch(input string name, input int expv, input logic [31:0] actv);
        $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, expv, actv);
    endtask

    // inputs settle one unit after the edge, so the model samples them here
    always @(posedge clk) begin : model_step
        mario_pkg::state_t ns;
        if (rst) begin
            m_state = mario_pkg::INITIAL;
            m_x     = int'(mario_pkg::START_X);
            m_y     = int'(mario_pkg::START_Y);
            m_vx    = 0;
            m_vy    = 0;
            m_face  = 1'b1;
            m_cnt   = 0;
            armed   = 1'b1;
        end else if (armed) begin
            ns = next_state(grounded(m_x, m_y), at_ladder(m_x, m_y));
            move_body();
            m_state = ns;
        end
    end

    always @(negedge clk) begin : compare_step
        mario_pkg::frame_t ef;
        if (armed) begin
            ef = expected_frame();
            if (x !== m_x) begin
                show_mismatch("x", m_x, x);
                x_errors++;
            end
            if (y !== m_y) begin
                show_mismatch("y", m_y, y);
                y_errors++;
            end
            if (state !== m_state) begin
                show_mismatch("state", m_state, state);
                state_errors++;
            end
            if (frame !== ef) begin
                show_mismatch("frame", ef, frame);
                frame_errors++;
            end
        end
    end

endmodule

`default_nettype wire

//--- mario.sv
`default_nettype none

module mario (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              over,
    input  mario_pkg::keys_t  keys,
    output mario_pkg::x_t     x,
    output mario_pkg::y_t     y,
    output mario_pkg::state_t state,
    output mario_pkg::frame_t frame
);

    mario_pkg::vel_x_t vel_x;
    mario_pkg::vel_y_t vel_y;
    logic              facing_left;
    logic [4:0]        anim_count;
    logic              on_ground;
    logic              on_ladder;
    logic              blocked_left;
    logic              blocked_right;
    logic              land_hit;
    mario_pkg::y_t     land_y;
    logic              ceil_hit;

    mario_collision i_collision (
        .x             (x),
        .y             (y),
        .vel_y         (vel_y),
        .on_ground     (on_ground),
        .on_ladder     (on_ladder),
        .blocked_left  (blocked_left),
        .blocked_right (blocked_right),
        .land_hit      (land_hit),
        .land_y        (land_y),
        .ceil_hit      (ceil_hit)
    );

    mario_motion i_motion (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .keys        (keys),
        .land_hit    (land_hit),
        .land_y      (land_y),
        .ceil_hit    (ceil_hit),
        .x           (x),
        .y           (y),
        .vel_x       (vel_x),
        .vel_y       (vel_y),
        .facing_left (facing_left),
        .anim_count  (anim_count)
    );

    mario_fsm i_fsm (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .over          (over),
        .keys          (keys),
        .on_ground     (on_ground),
        .on_ladder     (on_ladder),
        .blocked_left  (blocked_left),
        .blocked_right (blocked_right),
        .vel_y         (vel_y),
        .state         (state)
    );

    mario_sprite i_sprite (
        .state       (state),
        .anim_count  (anim_count),
        .facing_left (facing_left),
        .vel_x       (vel_x),
        .keys        (keys),
        .frame       (frame)
    );

endmodule

`default_nettype wire

//--- mario_sprite.sv
`default_nettype none

module mario_sprite (
    input  mario_pkg::state_t state,
    input  logic [4:0]        anim_count,
    input  logic              facing_left,
    input  mario_pkg::vel_x_t vel_x,
    input  mario_pkg::keys_t  keys,
    output mario_pkg::frame_t frame
);

    always_comb begin
        case (state)
            mario_pkg::FLYING: begin
                frame = facing_left ? mario_pkg::FLY_LEFT : mario_pkg::FLY_RIGHT;
            end
            mario_pkg::WALKING: begin
                // stride order 1, 3, 2, 3
                case (anim_count[3:2])
                    2'd0: frame = (vel_x > 0) ? mario_pkg::WALK_RIGHT1 : mario_pkg::WALK_LEFT1;
                    2'd2: frame = (vel_x > 0) ? mario_pkg::WALK_RIGHT2 : mario_pkg::WALK_LEFT2;
                    default: frame = (vel_x > 0) ? mario_pkg::WALK_RIGHT3 : mario_pkg::WALK_LEFT3;
                endcase
            end
            mario_pkg::DYING: begin
                case (anim_count[4:3])
                    2'd0: frame = mario_pkg::DIE1;
                    2'd1: frame = mario_pkg::DIE2;
                    2'd2: frame = mario_pkg::DIE3;
                    default: frame = mario_pkg::DIE4;
                endcase
            end
            mario_pkg::CLIMBING: begin
                if ((keys.up || keys.down) && anim_count[2]) begin
                    frame = mario_pkg::CLIMB2;
                end else begin
                    frame = mario_pkg::CLIMB1;
                end
            end
            default: begin
                frame = facing_left ? mario_pkg::WALK_LEFT3 : mario_pkg::WALK_RIGHT3;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- mario_fsm.sv
`default_nettype none

module mario_fsm (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              over,
    input  mario_pkg::keys_t  keys,
    input  logic              on_ground,
    input  logic              on_ladder,
    input  logic              blocked_left,
    input  logic              blocked_right,
    input  mario_pkg::vel_y_t vel_y,
    output mario_pkg::state_t state
);

    mario_pkg::state_t next_state;

    always_ff @(posedge clk) begin
        state <= next_state;
    end

    always_comb begin
        next_state = state;
        if (rst) begin
            next_state = mario_pkg::INITIAL;
        end else if (state == mario_pkg::INITIAL) begin
            if (start) begin
                next_state = mario_pkg::STANDING;
            end
        end else if (state == mario_pkg::DYING) begin
            // only reset leaves
            next_state = mario_pkg::DYING;
        end else if (over) begin
            next_state = mario_pkg::DYING;
        end else begin
            case (state)
                mario_pkg::STANDING, mario_pkg::WALKING: begin
                    if (!on_ground) begin
                        next_state = mario_pkg::FLYING;
                    end else if (keys.jump) begin
                        next_state = mario_pkg::JUMPING;
                    end else if ((keys.up || keys.down) && on_ladder) begin
                        next_state = mario_pkg::CLIMBING;
                    end else if (keys.left || keys.right) begin
                        next_state = mario_pkg::WALKING;
                    end else begin
                        next_state = mario_pkg::STANDING;
                    end
                end
                mario_pkg::JUMPING: begin
                    next_state = mario_pkg::FLYING;
                end
                mario_pkg::FLYING: begin
                    if (on_ground && vel_y >= 0) begin
                        next_state = mario_pkg::STANDING;
                    end
                end
                mario_pkg::CLIMBING: begin
                    if (on_ground && keys.jump) begin
                        next_state = mario_pkg::JUMPING;
                    end else if ((keys.left && !blocked_left) ||
                                 (keys.right && !blocked_right)) begin
                        next_state = mario_pkg::WALKING;
                    end else if (on_ladder) begin
                        next_state = mario_pkg::CLIMBING;
                    end else begin
                        next_state = mario_pkg::STANDING;
                    end
                end
                default: begin
                    next_state = mario_pkg::INITIAL;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mario_motion.sv
`default_nettype none

module mario_motion (
    input  logic              clk,
    input  logic              rst,
    input  mario_pkg::state_t state,
    input  mario_pkg::keys_t  keys,
    input  logic              land_hit,
    input  mario_pkg::y_t     land_y,
    input  logic              ceil_hit,
    output mario_pkg::x_t     x,
    output mario_pkg::y_t     y,
    output mario_pkg::vel_x_t vel_x,
    output mario_pkg::vel_y_t vel_y,
    output logic              facing_left,
    output logic [4:0]        anim_count
);

    logic signed [11:0] x_step;
    logic               x_lo;
    logic               x_hi;
    logic signed [13:0] y_fly;
    logic [9:0]         feet_climb;

    // horizontal step with the speed held before the edge
    assign x_step = $signed({2'b00, x}) + vel_x;
    assign x_lo   = x_step < $signed({2'b00, mario_pkg::LEFT_EDGE});
    assign x_hi   = x_step + $signed({2'b00, mario_pkg::WIDTH}) >
                    $signed({2'b00, mario_pkg::RIGHT_EDGE});

    assign y_fly      = $signed({5'b0, y}) + mario_pkg::vel_step(vel_y);
    assign feet_climb = {1'b0, y} + {1'b0, mario_pkg::HEIGHT} + {1'b0, mario_pkg::CLIMB_SPEED};

    always_ff @(posedge clk) begin
        if (rst) begin
            x           <= mario_pkg::START_X;
            y           <= mario_pkg::START_Y;
            vel_x       <= '0;
            vel_y       <= '0;
            facing_left <= 1'b1;
            anim_count  <= '0;
        end else begin
            case (state)
                mario_pkg::INITIAL: begin
                    x <= mario_pkg::START_X;
                    y <= mario_pkg::START_Y;
                end
                mario_pkg::JUMPING: begin
                    vel_y <= -mario_pkg::JUMP_VEL;
                end
                mario_pkg::FLYING: begin
                    anim_count <= anim_count + 5'd1;
                    if (ceil_hit) begin
                        y     <= mario_pkg::TOP_EDGE;
                        vel_y <= '0;
                    end else if (land_hit) begin
                        y     <= land_y;
                        vel_y <= '0;
                    end else begin
                        y     <= y_fly[8:0];
                        vel_y <= vel_y + mario_pkg::GRAVITY;
                    end
                    if (x_lo) begin
                        x     <= mario_pkg::LEFT_EDGE;
                        vel_x <= '0;
                    end else if (x_hi) begin
                        x     <= mario_pkg::RIGHT_EDGE - mario_pkg::WIDTH;
                        vel_x <= '0;
                    end else begin
                        x <= x_step[9:0];
                    end
                end
                mario_pkg::WALKING: begin
                    anim_count <= anim_count + 5'd1;
                    if (keys.left) begin
                        vel_x       <= -mario_pkg::WALK_SPEED;
                        facing_left <= 1'b1;
                    end else if (keys.right) begin
                        vel_x       <= mario_pkg::WALK_SPEED;
                        facing_left <= 1'b0;
                    end
                    if (x_lo) begin
                        x <= mario_pkg::LEFT_EDGE;
                    end else if (x_hi) begin
                        x <= mario_pkg::RIGHT_EDGE - mario_pkg::WIDTH;
                    end else begin
                        x <= x_step[9:0];
                    end
                end
                mario_pkg::STANDING: begin
                    vel_x <= '0;
                    vel_y <= '0;
                end
                mario_pkg::DYING: begin
                    vel_x      <= '0;
                    vel_y      <= '0;
                    anim_count <= anim_count + 5'd1;
                end
                mario_pkg::CLIMBING: begin
                    vel_x <= '0;
                    vel_y <= '0;
                    if (keys.up || keys.down) begin
                        anim_count <= anim_count + 5'd1;
                    end
                    if (keys.up) begin
                        if (y < mario_pkg::TOP_EDGE + mario_pkg::CLIMB_SPEED) begin
                            y <= mario_pkg::TOP_EDGE;
                        end else begin
                            y <= y - mario_pkg::CLIMB_SPEED;
                        end
                    end else if (keys.down) begin
                        // feet stay on the floor line
                        if (feet_climb > {1'b0, mario_pkg::BOTTOM_EDGE}) begin
                            y <= mario_pkg::BOTTOM_EDGE - mario_pkg::HEIGHT;
                        end else begin
                            y <= y + mario_pkg::CLIMB_SPEED;
                        end
                    end
                end
                default: begin
                    vel_x <= '0;
                    vel_y <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mario_collision.sv
`default_nettype none

module mario_collision (
    input  mario_pkg::x_t     x,
    input  mario_pkg::y_t     y,
    input  mario_pkg::vel_y_t vel_y,
    output logic              on_ground,
    output logic              on_ladder,
    output logic              blocked_left,
    output logic              blocked_right,
    output logic              land_hit,
    output mario_pkg::y_t     land_y,
    output logic              ceil_hit
);

    logic [10:0]                         x_right;
    logic [9:0]                          feet;
    logic signed [13:0]                  y_next;
    logic signed [13:0]                  feet_next;
    logic [mario_pkg::NUM_PLATFORMS-1:0] overlap;
    logic                                floor_next;
    logic                                plat_next;
    mario_pkg::y_t                       plat_y;

    assign x_right   = {1'b0, x} + {1'b0, mario_pkg::WIDTH};
    assign feet      = {1'b0, y} + {1'b0, mario_pkg::HEIGHT};
    assign y_next    = $signed({5'b0, y}) + mario_pkg::vel_step(vel_y);
    assign feet_next = y_next + $signed({5'b0, mario_pkg::HEIGHT});

    assign blocked_left  = x <= mario_pkg::LEFT_EDGE;
    assign blocked_right = x_right >= {1'b0, mario_pkg::RIGHT_EDGE};

    // horizontal overlap of the box with each platform
    always_comb begin
        for (int i = 0; i < mario_pkg::NUM_PLATFORMS; i++) begin
            overlap[i] = (x < mario_pkg::PLATFORMS[i].rx) &&
                         (x_right > {1'b0, mario_pkg::PLATFORMS[i].lx});
        end
    end

    always_comb begin
        on_ground = feet >= {1'b0, mario_pkg::BOTTOM_EDGE};
        for (int i = 0; i < mario_pkg::NUM_PLATFORMS; i++) begin
            if (overlap[i] && feet >= {1'b0, mario_pkg::PLATFORMS[i].ly} &&
                    feet <= {1'b0, mario_pkg::PLATFORMS[i].ry}) begin
                on_ground = 1'b1;
            end
        end
    end

    always_comb begin
        on_ladder = 1'b0;
        for (int i = 0; i < mario_pkg::NUM_LADDERS; i++) begin
            if (x >= mario_pkg::LADDERS[i].lx && x <= mario_pkg::LADDERS[i].rx &&
                    y > mario_pkg::LADDERS[i].ly && y < mario_pkg::LADDERS[i].ry) begin
                on_ladder = 1'b1;
            end
        end
    end

    // walk backwards so the first platform in the table wins
    always_comb begin
        plat_next = 1'b0;
        plat_y    = '0;
        for (int i = mario_pkg::NUM_PLATFORMS - 1; i >= 0; i--) begin
            if (overlap[i] &&
                    feet_next > $signed({5'b0, mario_pkg::PLATFORMS[i].ly}) &&
                    feet_next < $signed({5'b0, mario_pkg::PLATFORMS[i].ry})) begin
                plat_next = 1'b1;
                plat_y    = mario_pkg::PLATFORMS[i].ly - mario_pkg::HEIGHT;
            end
        end
    end

    assign floor_next = feet_next > $signed({5'b0, mario_pkg::BOTTOM_EDGE});
    assign ceil_hit   = y_next < $signed({5'b0, mario_pkg::TOP_EDGE});
    assign land_hit   = !ceil_hit && (floor_next || plat_next);
    assign land_y     = floor_next ? mario_pkg::BOTTOM_EDGE - mario_pkg::HEIGHT : plat_y;

endmodule

`default_nettype wire

//--- mario_pkg.sv
`default_nettype none

package mario_pkg;

    typedef logic [9:0] x_t;
    typedef logic [8:0] y_t;
    typedef logic signed [12:0] vel_y_t;
    typedef logic signed [9:0] vel_x_t;

    typedef enum logic [2:0] {
        INITIAL  = 3'd0,
        FLYING   = 3'd1,
        JUMPING  = 3'd2,
        WALKING  = 3'd3,
        STANDING = 3'd4,
        DYING    = 3'd5,
        CLIMBING = 3'd6
    } state_t;

    // sprite codes as the renderer expects them
    typedef enum logic [3:0] {
        STAND       = 4'd0,
        WALK_LEFT1  = 4'd1,
        WALK_LEFT2  = 4'd2,
        WALK_LEFT3  = 4'd3,
        WALK_RIGHT1 = 4'd4,
        WALK_RIGHT2 = 4'd5,
        FLY_LEFT    = 4'd6,
        FLY_RIGHT   = 4'd7,
        CLIMB1      = 4'd8,
        CLIMB2      = 4'd9,
        DIE1        = 4'd10,
        DIE2        = 4'd11,
        DIE3        = 4'd12,
        DIE4        = 4'd13,
        WALK_RIGHT3 = 4'd14
    } frame_t;

    typedef struct packed {
        logic jump;
        logic down;
        logic right;
        logic left;
        logic up;
    } keys_t;

    typedef struct packed {
        x_t lx;
        y_t ly;
        x_t rx;
        y_t ry;
    } rect_t;

    // playfield, y grows downward
    localparam y_t TOP_EDGE    = 9'd5;
    localparam y_t BOTTOM_EDGE = 9'd461;
    localparam x_t LEFT_EDGE   = 10'd5;
    localparam x_t RIGHT_EDGE  = 10'd640;

    localparam x_t WIDTH   = 10'd34;
    localparam y_t HEIGHT  = 9'd36;
    localparam x_t START_X = 10'd450;
    localparam y_t START_Y = 9'd425;

    localparam vel_x_t WALK_SPEED  = 10'sd4;
    // vertical speeds in tenths of a pixel
    localparam vel_y_t JUMP_VEL    = 13'sd50;
    localparam vel_y_t GRAVITY     = 13'sd3;
    localparam y_t     CLIMB_SPEED = 9'd3;

    localparam int NUM_PLATFORMS = 6;
    localparam int NUM_LADDERS   = 5;

    localparam rect_t PLATFORMS [NUM_PLATFORMS] = '{
        '{10'd250, 9'd53,  10'd388, 9'd70},
        '{10'd0,   9'd115, 10'd591, 9'd131},
        '{10'd49,  9'd197, 10'd640, 9'd213},
        '{10'd0,   9'd286, 10'd591, 9'd302},
        '{10'd49,  9'd376, 10'd640, 9'd393},
        '{10'd0,   9'd461, 10'd640, 9'd479}
    };

    localparam rect_t LADDERS [NUM_LADDERS] = '{
        '{10'd339, 9'd15,  10'd353, 9'd81},
        '{10'd541, 9'd77,  10'd555, 9'd163},
        '{10'd48,  9'd159, 10'd62,  9'd252},
        '{10'd546, 9'd248, 10'd560, 9'd342},
        '{10'd53,  9'd338, 10'd67,  9'd427}
    };

    // whole pixels per cycle, truncated toward zero
    function automatic vel_y_t vel_step(input vel_y_t v);
        return v / 13'sd10;
    endfunction

endpackage

`default_nettype wire
